/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi1_bridge_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* hw/bus_pkg.sv */
`include "spi1_defines.svh"

package bus_pkg;
    typedef logic [`SPI1_ADDR_WIDTH-1:0] addr_t;  // Bus address
    typedef logic [`SPI1_DATA_WIDTH-1:0] data_t;  // Bus data byte
endpackage

/* hw/bus_ram.sv */
`timescale 1ns/1ns
`include "spi1_defines.svh"

module bus_ram (
    input  logic           clock,
    input  logic           reset_i,
    input  bus_pkg::addr_t bus_addr_i,
    input  bus_pkg::data_t bus_wdata_i,
    input  logic           bus_we_i,
    input  logic           bus_cycle_i,
    output bus_pkg::data_t bus_rdata_o,
    output logic           bus_ack_o
);
    import bus_pkg::*;

    localparam int RAM_BITS = `SPI1_RAM_ADDR_BITS;
    localparam int DEPTH    = 2 ** RAM_BITS;

    data_t               mem [DEPTH];
    logic [RAM_BITS-1:0] index;
    logic [1:0]          wait_count;
    logic                access;

    assign index  = bus_addr_i[RAM_BITS-1:0];               // Upper bits alias
    assign access = bus_cycle_i && (wait_count == 2'd1);    // Second cycle seen

    always_ff @(posedge clock) begin
        if (reset_i) begin
            wait_count <= '0;
            bus_ack_o  <= 1'b0;
        end else begin
            bus_ack_o <= access;
            if (!bus_cycle_i) begin
                wait_count <= '0;
            end else if (wait_count != 2'd2) begin
                wait_count <= wait_count + 1'b1;   // Stops at 2, one ack per cycle
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            if (bus_we_i) begin
                mem[index] <= bus_wdata_i;
            end
            bus_rdata_o <= mem[index];
        end
    end
endmodule

/* hw/spi1_bridge_top.sv */
`timescale 1ns/1ns

module spi1_bridge_top (
    input  logic clock,
    input  logic reset_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);
    import bus_pkg::*;

    logic  sck_rise;
    logic  sck_fall;
    logic  cs_active;
    logic  cs_start;
    logic  cs_end;
    logic  pico_sync;
    data_t rx_byte;
    logic  rx_valid;
    data_t tx_byte;
    logic  tx_load;
    addr_t bus_addr;
    data_t bus_wdata;
    data_t bus_rdata;
    logic  bus_we;
    logic  bus_cycle;
    logic  bus_ack;

    spi1_sync sync_i (
        .clock      (clock),
        .reset_i    (reset_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_pico_i (spi_pico_i),
        .sck_rise_o (sck_rise),
        .sck_fall_o (sck_fall),
        .cs_active_o(cs_active),
        .cs_start_o (cs_start),
        .cs_end_o   (cs_end),
        .pico_o     (pico_sync)
    );

    spi1_target target_i (
        .clock      (clock),
        .reset_i    (reset_i),
        .sck_rise_i (sck_rise),
        .sck_fall_i (sck_fall),
        .cs_start_i (cs_start),
        .cs_active_i(cs_active),
        .pico_i     (pico_sync),
        .tx_load_i  (tx_load),
        .tx_byte_i  (tx_byte),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .spi_poci_o (spi_poci_o)
    );

    spi1_controller controller_i (
        .clock      (clock),
        .reset_i    (reset_i),
        .cs_start_i (cs_start),
        .cs_end_i   (cs_end),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .bus_rdata_i(bus_rdata),
        .bus_ack_i  (bus_ack),
        .bus_addr_o (bus_addr),
        .bus_wdata_o(bus_wdata),
        .bus_we_o   (bus_we),
        .bus_cycle_o(bus_cycle),
        .tx_byte_o  (tx_byte),
        .tx_load_o  (tx_load),
        .spi_stall_o(spi_stall_o)
    );

    bus_ram ram_i (
        .clock      (clock),
        .reset_i    (reset_i),
        .bus_addr_i (bus_addr),
        .bus_wdata_i(bus_wdata),
        .bus_we_i   (bus_we),
        .bus_cycle_i(bus_cycle),
        .bus_rdata_o(bus_rdata),
        .bus_ack_o  (bus_ack)
    );
endmodule

/* hw/spi1_cmd_pkg.sv */
`include "spi1_defines.svh"

package spi1_cmd_pkg;
    typedef enum logic [1:0] {
        MODE_AT   = 2'd0,  // Address bytes follow
        MODE_NEXT = 2'd1,  // Previous address plus one
        MODE_PREV = 2'd2,  // Previous address minus one
        MODE_SAME = 2'd3   // Previous address again
    } addr_mode_e;

    typedef struct packed {
        logic                         we;        // Write flag
        addr_mode_e                   mode;      // Address formation
        logic                         reserved;
        logic [`SPI1_ADDR_WIDTH-17:0] addr_hi;   // Address 19:16, at only
    } cmd_t;

    typedef enum logic [2:0] {
        IDLE,      // Waiting for command byte
        ADDR_MID,  // Waiting for address 15:8
        ADDR_LOW,  // Waiting for address 7:0
        DATA,      // Waiting for write data
        BUS,       // Bus cycle in flight
        READ_OUT,  // Read data shifting out
        DONE       // Frame complete
    } frame_state_e;
endpackage

/* hw/spi1_controller.sv */
`timescale 1ns/1ns

module spi1_controller (
    input  logic           clock,
    input  logic           reset_i,
    input  logic           cs_start_i,
    input  logic           cs_end_i,
    input  bus_pkg::data_t rx_byte_i,
    input  logic           rx_valid_i,
    input  bus_pkg::data_t bus_rdata_i,
    input  logic           bus_ack_i,
    output bus_pkg::addr_t bus_addr_o,
    output bus_pkg::data_t bus_wdata_o,
    output logic           bus_we_o,
    output logic           bus_cycle_o,
    output bus_pkg::data_t tx_byte_o,
    output logic           tx_load_o,
    output logic           spi_stall_o
);
    import bus_pkg::*;
    import spi1_cmd_pkg::*;

    frame_state_e state;
    frame_state_e state_d;
    cmd_t         cmd;
    addr_t        addr_cmd;   // Address selected by the command byte

    assign cmd = cmd_t'(rx_byte_i);

    always_comb begin
        case (cmd.mode)
            MODE_AT:   addr_cmd = {cmd.addr_hi, bus_addr_o[15:0]};
            MODE_NEXT: addr_cmd = bus_addr_o + 1'b1;   // Wraps at 2^20
            MODE_PREV: addr_cmd = bus_addr_o - 1'b1;
            default:   addr_cmd = bus_addr_o;
        endcase
    end

    always_comb begin
        state_d = state;
        case (state)
            IDLE: begin
                if (rx_valid_i) begin
                    if (cmd.mode == MODE_AT) begin
                        state_d = ADDR_MID;
                    end else begin
                        state_d = cmd.we ? DATA : BUS;
                    end
                end
            end
            ADDR_MID: if (rx_valid_i) state_d = ADDR_LOW;
            ADDR_LOW: if (rx_valid_i) state_d = bus_we_o ? DATA : BUS;
            DATA:     if (rx_valid_i) state_d = BUS;
            BUS:      if (bus_ack_i) state_d = bus_we_o ? DONE : READ_OUT;
            READ_OUT: if (rx_valid_i) state_d = DONE;   // Dummy byte clocked
            default:  state_d = state;                   // Hold until frame ends
        endcase
        if (cs_start_i || cs_end_i) begin
            state_d = IDLE;   // Abandons any cycle in flight
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            state       <= IDLE;
            bus_cycle_o <= 1'b0;
        end else begin
            state       <= state_d;
            bus_cycle_o <= (state_d == BUS);
        end
    end

    // Address survives across frames for next, prev and same
    always_ff @(posedge clock) begin
        if (reset_i) begin
            bus_addr_o <= '0;
            bus_we_o   <= 1'b0;
        end else if (rx_valid_i) begin
            case (state)
                IDLE: begin
                    bus_addr_o <= addr_cmd;
                    bus_we_o   <= cmd.we;
                end
                ADDR_MID: bus_addr_o <= {bus_addr_o[19:16], rx_byte_i, bus_addr_o[7:0]};
                ADDR_LOW: bus_addr_o <= {bus_addr_o[19:8], rx_byte_i};
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == DATA && rx_valid_i) begin
            bus_wdata_o <= rx_byte_i;
        end
    end

    // Host holds off the dummy byte for the whole bus cycle
    assign spi_stall_o = bus_cycle_o;

    assign tx_byte_o = bus_rdata_i;
    assign tx_load_o = bus_ack_i && (state == BUS) && !bus_we_o;   // Read data to shifter
endmodule

/* hw/spi1_defines.svh */
`ifndef SPI1_DEFINES_SVH
`define SPI1_DEFINES_SVH

// Bus address width in bits
`define SPI1_ADDR_WIDTH 20

// Bus data width in bits
`define SPI1_DATA_WIDTH 8

// Address bits decoded by the on-chip RAM, higher bits alias
`define SPI1_RAM_ADDR_BITS 10

// Flops per SPI pin synchronizer
`define SPI1_SYNC_STAGES 2

`endif

/* hw/spi1_sync.sv */
`timescale 1ns/1ns
`include "spi1_defines.svh"

module spi1_sync (
    input  logic clock,
    input  logic reset_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic sck_rise_o,
    output logic sck_fall_o,
    output logic cs_active_o,
    output logic cs_start_o,
    output logic cs_end_o,
    output logic pico_o
);
    localparam int STAGES = `SPI1_SYNC_STAGES;

    logic [STAGES-1:0] sck_sync;
    logic [STAGES-1:0] cs_n_sync;
    logic [STAGES-1:0] pico_sync;
    logic              sck_prev;   // Edge detect stage
    logic              cs_n_prev;
    logic              sck_now;
    logic              cs_n_now;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            sck_sync  <= '0;
            cs_n_sync <= '1;     // Deselected
            pico_sync <= '0;
            sck_prev  <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[STAGES-2:0], spi_sck_i};
            cs_n_sync <= {cs_n_sync[STAGES-2:0], spi_cs_n_i};
            pico_sync <= {pico_sync[STAGES-2:0], spi_pico_i};
            sck_prev  <= sck_now;
            cs_n_prev <= cs_n_now;
        end
    end

    assign sck_now  = sck_sync[STAGES-1];
    assign cs_n_now = cs_n_sync[STAGES-1];

    assign sck_rise_o  = sck_now & ~sck_prev;
    assign sck_fall_o  = ~sck_now & sck_prev;
    assign cs_active_o = ~cs_n_now;
    assign cs_start_o  = ~cs_n_now & cs_n_prev;   // Frame begins
    assign cs_end_o    = cs_n_now & ~cs_n_prev;   // Frame ends
    assign pico_o      = pico_sync[STAGES-1];
endmodule

/* hw/spi1_target.sv */
`timescale 1ns/1ns

module spi1_target (
    input  logic           clock,
    input  logic           reset_i,
    input  logic           sck_rise_i,
    input  logic           sck_fall_i,
    input  logic           cs_start_i,
    input  logic           cs_active_i,
    input  logic           pico_i,
    input  logic           tx_load_i,
    input  bus_pkg::data_t tx_byte_i,
    output bus_pkg::data_t rx_byte_o,
    output logic           rx_valid_o,
    output logic           spi_poci_o
);
    import bus_pkg::*;

    localparam int BITS        = $bits(data_t);
    localparam int COUNT_WIDTH = $clog2(BITS);

    logic [COUNT_WIDTH-1:0] bit_count;
    logic [BITS-2:0]        rx_shift;   // First seven bits of a byte
    data_t                  tx_shift;
    logic                   sample;
    logic                   last_bit;
    logic                   shift_out;

    assign sample    = cs_active_i && sck_rise_i;
    assign last_bit  = (bit_count == COUNT_WIDTH'(BITS - 1));
    // The falling edge that closes a byte leaves the next byte's MSB in place
    assign shift_out = cs_active_i && sck_fall_i && (bit_count != '0);

    always_ff @(posedge clock) begin
        if (reset_i) begin
            bit_count  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cs_start_i) begin
                bit_count <= '0;              // Realign to byte boundary
            end else if (sample) begin
                bit_count  <= bit_count + 1'b1;
                rx_valid_o <= last_bit;       // Eighth rising edge
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sample) begin
            rx_shift <= {rx_shift[BITS-3:0], pico_i};   // MSB first
            if (last_bit) begin
                rx_byte_o <= {rx_shift, pico_i};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            tx_shift <= '0;
        end else if (tx_load_i) begin
            tx_shift <= tx_byte_i;                      // Load wins over shift
        end else if (shift_out) begin
            tx_shift <= {tx_shift[BITS-2:0], 1'b0};
        end
    end

    assign spi_poci_o = tx_shift[BITS-1];
endmodule

/* sources.f */
+incdir+hw
hw/spi1_cmd_pkg.sv
hw/bus_pkg.sv
hw/spi1_sync.sv
hw/spi1_target.sv
hw/spi1_controller.sv
hw/bus_ram.sv
hw/spi1_bridge_top.sv
verif/clock_gen.sv
verif/spi1_bridge_properties.sv
verif/spi1_bridge_tb.sv

/* verif/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_o
);
    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #1 reset_o = 1'b0;   // Same offset as the pin stimulus
    end
endmodule

/* verif/spi1_bridge_properties.sv */
`timescale 1ns/1ns

module spi1_bridge_properties (
    input logic           clock,
    input logic           reset_i,
    input logic           cs_start_i,
    input logic           cs_end_i,
    input logic           bus_ack_i,
    input logic           bus_cycle_i,
    input logic           stall_i,
    input bus_pkg::addr_t bus_addr_i,
    input logic           bus_we_i
);
    int failures = 0;   // Summed into the end of run summary

    cycle_ends_after_ack: assert property (
        @(posedge clock) disable iff (reset_i) bus_ack_i |=> !bus_cycle_i
    ) else begin
        failures++;
        $error("bus_cycle still high on the clock after bus_ack");
    end

    // cs_end_i marks the pin edge two clocks late, so this is 3 clocks after the pin
    stall_low_after_cs_rise: assert property (
        @(posedge clock) disable iff (reset_i) cs_end_i |=> !stall_i
    ) else begin
        failures++;
        $error("spi_stall_o high 3 clocks after spi_cs_n_i rose");
    end

    cycle_low_after_cs_fall: assert property (
        @(posedge clock) disable iff (reset_i) cs_start_i |=> !bus_cycle_i
    ) else begin
        failures++;
        $error("bus_cycle high 3 clocks after spi_cs_n_i fell");
    end

    addr_stable_in_cycle: assert property (
        @(posedge clock) disable iff (reset_i)
            bus_cycle_i && $past(bus_cycle_i) |-> $stable(bus_addr_i) && $stable(bus_we_i)
    ) else begin
        failures++;
        $error("bus_addr or bus_we changed while bus_cycle was high");
    end
endmodule

bind spi1_controller spi1_bridge_properties props_i (
    .clock      (clock),
    .reset_i    (reset_i),
    .cs_start_i (cs_start_i),
    .cs_end_i   (cs_end_i),
    .bus_ack_i  (bus_ack_i),
    .bus_cycle_i(bus_cycle_o),
    .stall_i    (spi_stall_o),
    .bus_addr_i (bus_addr_o),
    .bus_we_i   (bus_we_o)
);

/* verif/spi1_bridge_tb.sv */
`timescale 1ns/1ns
`include "spi1_defines.svh"

module spi1_bridge_tb;
    import bus_pkg::*;
    import spi1_cmd_pkg::*;

    localparam int PERIOD_NS   = 8;
    localparam int HALF        = 5;    // SCK half-period in clocks
    localparam int STALL_LIMIT = 20;
    localparam int RAM_BITS    = `SPI1_RAM_ADDR_BITS;
    localparam int FRAMES      = 90;
    // Four bytes, gaps and two stall waits
    localparam int FRAME_NS    = (4 * 17 * HALF + 3 * HALF + 2 * STALL_LIMIT) * PERIOD_NS;

    logic  clock;
    logic  reset_i;
    logic  spi_sck;
    logic  spi_cs_n;
    logic  spi_pico;
    logic  spi_poci;
    logic  spi_stall;
    data_t ref_mem [2**RAM_BITS];   // Expected RAM contents
    logic  known [2**RAM_BITS];     // Written at least once
    addr_t track;                   // Model of the bridge address register
    string test_name;
    int    stall_clocks = 0;        // Clocks with spi_stall_o high in this frame
    int    test_checks = 0;
    int    test_errors = 0;
    int    checks = 0;
    int    errors = 0;

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) clock_gen_i (
        .clock_o(clock),
        .reset_o(reset_i)
    );

    spi1_bridge_top spi1_bridge_top_i (
        .clock      (clock),
        .reset_i    (reset_i),
        .spi_sck_i  (spi_sck),
        .spi_cs_n_i (spi_cs_n),
        .spi_pico_i (spi_pico),
        .spi_poci_o (spi_poci),
        .spi_stall_o(spi_stall)
    );

    always @(posedge clock) begin
        if (spi_stall) begin
            stall_clocks++;
        end
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic wait_stall_low();
        int guard = 0;
        while (spi_stall && guard < STALL_LIMIT) begin
            wait_clocks(1);
            guard++;
        end
        if (spi_stall) begin
            test_errors++;
            $display("%s: spi_stall_o still high after %0d clocks", test_name, STALL_LIMIT);
        end
    endtask

    // Mode 0, MSB first, poci sampled just before each rising edge
    task automatic shift_bits(input data_t tx, input int nbits, output data_t rx);
        rx = '0;
        for (int i = 7; i >= 8 - nbits; i--) begin
            spi_pico = tx[i];
            wait_clocks(HALF);
            rx[i]   = spi_poci;
            spi_sck = 1'b1;
            wait_clocks(HALF);
            spi_sck = 1'b0;
        end
        wait_clocks(HALF);
    endtask

    task automatic send_header(input logic we, input addr_mode_e mode, input addr_t addr);
        data_t unused;
        spi_cs_n = 1'b0;
        wait_clocks(HALF);
        shift_bits({we, mode, 1'b0, addr[19:16]}, 8, unused);
        case (mode)
            MODE_AT: begin
                shift_bits(addr[15:8], 8, unused);
                shift_bits(addr[7:0], 8, unused);
                track = addr;
            end
            MODE_NEXT: track = track + 20'd1;   // Wraps modulo 2^20
            MODE_PREV: track = track - 20'd1;
            default:   track = track;
        endcase
    endtask

    task automatic run_frame(input logic we, input addr_mode_e mode, input addr_t addr,
                             input data_t wdata);
        data_t rdata;
        stall_clocks = 0;
        send_header(we, mode, addr);
        if (!we) begin
            wait_stall_low();   // Read data must be loaded before the dummy byte
        end
        shift_bits(we ? wdata : 8'h00, 8, rdata);
        wait_stall_low();
        spi_cs_n = 1'b1;
        wait_clocks(2 * HALF);
        if (stall_clocks == 0) begin
            test_errors++;
            $display("%s: spi_stall_o never rose during the frame at %05h", test_name, track);
        end
        if (we) begin
            ref_mem[track[RAM_BITS-1:0]] = wdata;   // Upper bits alias
            known[track[RAM_BITS-1:0]]   = 1'b1;
        end else if (known[track[RAM_BITS-1:0]]) begin
            test_checks++;
            assert (rdata == ref_mem[track[RAM_BITS-1:0]])
            else begin
                test_errors++;
                $display("Error: %s at %05h expected %02h actual %02h", test_name, track,
                         ref_mem[track[RAM_BITS-1:0]], rdata);
            end
        end
    endtask

    task automatic report_test();
        $display("%s: %0d reads checked, %0d errors", test_name, test_checks, test_errors);
        checks += test_checks;
        errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        addr_t      addr;
        addr_mode_e mode;
        data_t      scratch;
        spi_sck  = 1'b0;
        spi_cs_n = 1'b1;
        spi_pico = 1'b0;
        track    = '0;
        for (int i = 0; i < 2**RAM_BITS; i++) begin
            known[i] = 1'b0;
        end
        void'($urandom(8385));
        @(negedge reset_i);
        wait_clocks(2);

        test_name = "at_both_ends";
        run_frame(1'b1, MODE_AT, 20'h00000, 8'h3c);
        run_frame(1'b0, MODE_AT, 20'h00000, 8'h00);
        run_frame(1'b1, MODE_AT, 20'hfffff, 8'hc5);
        run_frame(1'b0, MODE_AT, 20'hfffff, 8'h00);
        run_frame(1'b0, MODE_AT, 20'h00000, 8'h00);
        report_test();

        test_name = "next_wrap";
        for (int i = 0; i < 8; i++) begin
            run_frame(i < 4, (i % 4 == 0) ? MODE_AT : MODE_NEXT, 20'hffffe, 8'(8'h10 + i));
        end
        report_test();

        test_name = "prev_wrap";
        for (int i = 0; i < 8; i++) begin
            run_frame(i < 4, (i % 4 == 0) ? MODE_AT : MODE_PREV, 20'h00001, 8'(8'h40 + i));
        end
        report_test();

        test_name = "same_address";
        run_frame(1'b1, MODE_AT, 20'h12345, 8'h77);
        for (int i = 0; i < 5; i++) begin
            run_frame(i % 2 == 1, MODE_SAME, '0, 8'($urandom));   // Read, write, read ...
        end
        report_test();

        test_name = "mixed_abandon";
        run_frame(1'b1, MODE_AT, 20'h20010, 8'h5a);   // Lands on RAM word 010
        run_frame(1'b0, MODE_AT, 20'h00010, 8'h00);
        stall_clocks = 0;
        send_header(1'b1, MODE_AT, 20'h00010);
        shift_bits(8'ha5, 4, scratch);                // Frame dropped mid data byte
        spi_cs_n = 1'b1;
        wait_clocks(2 * HALF);
        if (stall_clocks != 0) begin
            test_errors++;
            $display("%s: bus cycle started for the abandoned frame", test_name);
        end
        run_frame(1'b0, MODE_SAME, '0, 8'h00);
        run_frame(1'b1, MODE_NEXT, '0, 8'hc3);
        run_frame(1'b0, MODE_PREV, '0, 8'h00);
        run_frame(1'b0, MODE_NEXT, '0, 8'h00);
        report_test();

        test_name = "random";
        for (int n = 0; n < 16; n++) begin
            run_frame(1'b1, MODE_AT, {10'($urandom), 6'd0, 4'(n)}, 8'($urandom));
        end
        for (int n = 0; n < 40; n++) begin
            mode = addr_mode_e'(2'($urandom));
            addr = {10'($urandom), 6'd0, 4'($urandom)};
            run_frame($urandom % 2 == 0, mode, addr, 8'($urandom));
        end
        report_test();

        errors += spi1_bridge_top_i.controller_i.props_i.failures;
        $display("Summary: %0d reads checked, %0d bus property failures, %0d errors total",
                 checks, spi1_bridge_top_i.controller_i.props_i.failures, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * FRAMES * FRAME_NS);
        $display("Timeout: frames did not finish within %0d ns", 2 * FRAMES * FRAME_NS);
        $display("TESTS FAILED");
        $finish;
    end
endmodule
